//--- Makefile
TOP := tb_host_bus_hub

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- bench/tb_clock_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/100ps

module tb_clock_gen
(
    output logic sysclk,
    output logic rst
);

    localparam int RST_CYCLES = 8;

    initial
    begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;      // 20 ns period
    end

    // released just after an edge, like every other input
    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge sysclk);
        #2;
        rst = 1'b0;
    end

endmodule

//--- bench/tb_host_bus_hub.sv
// testbench for the register bus hub with directed tests, checks, random source and run limit
`timescale 1ns/100ps
`include "host_bus_settings.svh"

module tb_host_bus_hub;
    import host_bus_pkg::*;

    localparam int TICK        = `WDOG_TICK_CYCLES;
    localparam int TEST_CYCLES = 16 + 16 + 24 + 6 * 24 + 3 * 4 * TICK + 16;   // per test sum

    logic         sysclk, rst;
    logic [3:0]   board_id;
    host_rd_req_t fw_rd, eth_rd;
    host_wr_req_t fw_wr, eth_wr;
    logic [31:0]  reg_rdata_ext;
    logic         reg_rwait_ext, wdog_clear;
    logic         fw_grant_read, eth_grant_read, fw_grant_write, eth_grant_write;
    logic [15:0]  reg_raddr;
    wr_bus_t      wr_bus;
    logic [31:0]  reg_rdata;
    logic         reg_rwait, reg_rvalid, lreq, wdog_timeout;
    logic [3:0]   grants;                  // fw read, eth read, fw write, eth write
    int           errors = 0;
    int           checks = 0;
    logic [31:0]  lfsr = 32'h741b8163;

    assign grants = {fw_grant_read, eth_grant_read, fw_grant_write, eth_grant_write};

    tb_clock_gen clk_gen (.sysclk(sysclk), .rst(rst));

    host_bus_hub uut (
        .sysclk(sysclk), .rst(rst), .board_id(board_id),
        .fw_rd(fw_rd), .eth_rd(eth_rd), .fw_wr(fw_wr), .eth_wr(eth_wr),
        .reg_rdata_ext(reg_rdata_ext), .reg_rwait_ext(reg_rwait_ext), .wdog_clear(wdog_clear),
        .fw_grant_read(fw_grant_read), .eth_grant_read(eth_grant_read),
        .fw_grant_write(fw_grant_write), .eth_grant_write(eth_grant_write),
        .reg_raddr(reg_raddr), .wr_bus(wr_bus),
        .reg_rdata(reg_rdata), .reg_rwait(reg_rwait), .reg_rvalid(reg_rvalid),
        .lreq(lreq), .wdog_timeout(wdog_timeout)
    );

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic step();
        @(posedge sysclk);
        #2;                                // inputs change 2 ns after the edge
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            v    = {v[30:0], lfsr[0]};     // one step per bit taken
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // keep requesting until the grant shows or a few cycles pass
    task automatic await_grant(input int sel);
        int n;
        n = 0;
        step();
        while (!grants[sel] && n < 8)
        begin
            step();
            n++;
        end
        if (!grants[sel])
        begin
            errors++;
            $display("grant %0d never arrived, gave up at %0t", sel, $time);
        end
    endtask

    // returns 2 ns after the write edge
    task automatic reg_write(input logic from_eth, input logic [3:0] idx,
                             input logic [31:0] data);
        wr_bus_t b;
        b = {1'b1, 2'b00, `ADDR_MAIN, 8'd0, idx, data};
        if (from_eth)
        begin
            eth_wr.req = 1'b1;
            await_grant(0);
            eth_wr.bus = b;
        end
        else
        begin
            fw_wr.req = 1'b1;
            await_grant(1);
            fw_wr.bus = b;
        end
        step();
        fw_wr  = '0;
        eth_wr = '0;
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic reset_state();
        @(posedge sysclk);
        #3;
        check("grants in reset", 32'(grants), 32'd0);
        wait (rst == 1'b0);
        fw_rd.raddr = {`ADDR_MAIN, 8'd0, `REG_VERSION};
        #1;
        check("reg_rdata version", reg_rdata, `FW_VERSION);
        check("lreq", 32'(lreq), 32'd0);
        check("wdog_timeout", 32'(wdog_timeout), 32'd0);
        step();
        fw_rd.raddr = {`ADDR_MAIN, 8'd0, `REG_STATUS};
        #1;
        check("reg_rdata status", reg_rdata, {1'b0, 27'd0, board_id});
    endtask

    task automatic arbitration();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        check("grants idle", 32'(grants), 32'b1010);    // first edge out of reset
        step();
        r      = rand_bits(32);
        fw_rd  = {1'b0, r[15:0]};
        eth_rd = {1'b1, r[31:16]};
        r      = rand_bits(4);
        a      = rand_bits(16);
        d      = rand_bits(32);
        fw_wr  = {2'b00, r[1:0], a[15:0], d};           // wen low throughout
        a      = rand_bits(16);
        d      = rand_bits(32);
        eth_wr = {2'b10, r[3:2], a[15:0], d};
        step();
        #1;
        check("grants ethernet alone", 32'(grants), 32'b0101);
        check("reg_raddr", 32'(reg_raddr), 32'(eth_rd.raddr));
        check("wr_bus.wdata", wr_bus.wdata, eth_wr.bus.wdata);
        check("wr_bus control", 32'(wr_bus[50:32]), 32'(eth_wr.bus[50:32]));
        step();
        fw_rd.req = 1'b1;
        fw_wr.req = 1'b1;
        step();
        #1;
        check("grants both asking", 32'(grants), 32'b1010);
        check("reg_raddr", 32'(reg_raddr), 32'(fw_rd.raddr));
        check("wr_bus.wdata", wr_bus.wdata, fw_wr.bus.wdata);
        check("wr_bus control", 32'(wr_bus[50:32]), 32'(fw_wr.bus[50:32]));
        step();
        fw_rd  = '0;
        eth_rd = '0;
        fw_wr  = '0;
        eth_wr = '0;
    endtask

    task automatic register_access();
        logic [31:0] ip;
        logic [31:0] ext;
        ip  = rand_bits(32);
        ext = rand_bits(32);
        reg_write(1'b1, `REG_IPADDR, ip);  // written by Ethernet and read back through FireWire
        fw_rd = {1'b1, `ADDR_MAIN, 8'd0, `REG_IPADDR};
        await_grant(3);
        #1;
        check("reg_rdata ip address", reg_rdata, ip);
        step();
        fw_rd.raddr   = {`ADDR_EXT, ext[11:0]};
        reg_rdata_ext = ext;
        #1;
        check("reg_rwait external", 32'(reg_rwait), 32'd1);
        check("reg_rvalid first cycle", 32'(reg_rvalid), 32'd0);
        check("reg_rdata external", reg_rdata, ext);
        step();
        #1;
        check("reg_rvalid second cycle", 32'(reg_rvalid), 32'd1);
        step();
        fw_rd.raddr = {4'h3, 8'd0, `REG_IPADDR};   // unmapped space over ip address bits
        #1;
        check("reg_rdata unmapped", reg_rdata, ext);
        check("reg_rwait unmapped", 32'(reg_rwait), 32'd0);
        check("reg_rvalid unmapped", 32'(reg_rvalid), 32'd1);
        step();
        reg_rwait_ext = 1'b1;              // external wait state on the same read
        #1;
        check("reg_rwait external wait", 32'(reg_rwait), 32'd1);
        step();
        fw_rd         = '0;
        reg_rdata_ext = 32'd0;
        reg_rwait_ext = 1'b0;
    endtask

    // one PHY control write followed by the frame on lreq bit by bit
    task automatic link_request(input logic [31:0] data, input logic extra_start);
        logic       q[$];
        logic [2:0] typ;
        int         i;
        typ = data[12] ? `LREQ_REG_WR : `LREQ_REG_RD;
        q.push_back(1'b1);                 // start bit
        for (i = 2; i >= 0; i--)
            q.push_back(typ[i]);
        for (i = 11; i >= (data[12] ? 0 : 8); i--)
            q.push_back(data[i]);          // address followed by write data
        for (i = 0; i < 4; i++)
            q.push_back(1'b0);             // stop bit and idle
        reg_write(1'b0, `REG_PHYCTRL, data);
        for (i = 0; i < q.size(); i++)
        begin
            if (i > 0)
                step();
            if (extra_start && i == 2)
                fw_wr = {2'b11, 2'b00, `ADDR_MAIN, 8'd0, `REG_PHYCTRL, ~data};   // while busy
            if (extra_start && i == 3)
                fw_wr = '0;
            #1;
            check($sformatf("lreq bit %0d", i), 32'(lreq), 32'(q[i]));
        end
        fw_rd.raddr = {`ADDR_MAIN, 8'd0, `REG_PHYCTRL};
        #1;
        check("reg_rdata phy control", reg_rdata, extra_start ? ~data : data);
    endtask

    task automatic link_requests();
        logic [31:0] d;
        int          k;
        for (k = 0; k < 4; k++)
        begin
            d     = rand_bits(32);
            d[12] = k[0];                  // alternate read and write types
            link_request(d, 1'b0);
        end
        link_request(rand_bits(32), 1'b1);
    endtask

    task automatic watchdog_expiry();
        logic [31:0] r;
        int          p;
        int          n;
        r = rand_bits(2);
        p = int'(r[1:0]) + 1;
        reg_write(1'b0, `REG_WDOG, 32'(p));
        fw_rd.raddr = {`ADDR_MAIN, 8'd0, `REG_WDOG};
        #1;
        check("reg_rdata watchdog period", reg_rdata, 32'(p));
        for (n = 1; n <= p * TICK; n++)
        begin
            step();
            #1;
            check("wdog_timeout", 32'(wdog_timeout), 32'(n == p * TICK));
        end
        step();
        fw_rd.raddr = {`ADDR_MAIN, 8'd0, `REG_STATUS};
        wdog_clear  = 1'b1;
        #1;
        check("reg_rdata status timeout", reg_rdata, {1'b1, 27'd0, board_id});
        step();
        wdog_clear = 1'b0;
        #1;
        check("wdog_timeout after clear", 32'(wdog_timeout), 32'd0);
        reg_write(1'b0, `REG_WDOG, 32'(p));
        for (n = 1; n < 2 * p * TICK; n++)
        begin
            step();
            if (n == p * TICK - 2)
                fw_wr.bus = {3'b100, `ADDR_MAIN, 8'd0, `REG_STATUS, 32'd0};   // kick
            if (n == p * TICK - 1)
                fw_wr = '0;
            #1;
            check("wdog_timeout kicked", 32'(wdog_timeout), 32'(n == 2 * p * TICK - 1));
        end
        reg_write(1'b0, `REG_WDOG, 32'd0);
    endtask

    // ----------------------------------------
    // run
    // ----------------------------------------
    initial
    begin
        board_id      = 4'h6;
        fw_rd         = '0;
        eth_rd        = '0;
        fw_wr         = '0;
        eth_wr        = '0;
        reg_rdata_ext = 32'd0;
        reg_rwait_ext = 1'b0;
        wdog_clear    = 1'b0;
        reset_state();
        arbitration();
        register_access();
        link_requests();
        watchdog_expiry();
        step();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        #(2 * TEST_CYCLES * 20);
        $display("run did not finish in %0d cycles, stopped at %0t", 2 * TEST_CYCLES, $time);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/host_bus_pkg.sv
hdl/bus_arbiter.sv
hdl/read_data_mux.sv
hdl/board_regs.sv
hdl/watchdog_timer.sv
hdl/phy_request.sv
hdl/host_bus_hub.sv
bench/tb_clock_gen.sv
bench/tb_host_bus_hub.sv

//--- hdl/board_regs.sv
// board register block with write decode, write side strobes and read decode
`timescale 1ns/100ps
`include "host_bus_settings.svh"

module board_regs
(
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic [15:0]           reg_raddr,
    input  host_bus_pkg::wr_bus_t wr_bus,
    input  logic [3:0]            board_id,       // rotary switch
    input  logic                  wdog_timeout,
    output logic [31:0]           regs_rdata,
    output logic [15:0]           wdog_period,
    output logic                  wdog_kick,
    output logic                  wdog_period_wr,
    output logic                  lreq_start,
    output logic [2:0]            lreq_type,
    output logic [11:0]           lreq_data
);
    import host_bus_pkg::*;

    reg_addr_u   raddr_u;
    reg_addr_u   waddr_u;
    logic        reg_wr;                   // quadlet write into this block
    logic [31:0] phy_ctrl;                 // last PHY control word
    logic [31:0] ip_addr;

    assign raddr_u = reg_raddr;
    assign waddr_u = wr_bus.waddr;

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    assign reg_wr = wr_bus.wen && (waddr_u.regs.space == `ADDR_MAIN) &&
                    (waddr_u.regs.chan == 4'd0);

    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            phy_ctrl    <= 32'd0;
            ip_addr     <= 32'd0;
            wdog_period <= 16'd0;
        end
        else if (reg_wr)
        begin
            case (waddr_u.regs.reg_idx)
                `REG_PHYCTRL: phy_ctrl    <= wr_bus.wdata;
                `REG_WDOG:    wdog_period <= wr_bus.wdata[15:0];
                `REG_IPADDR:  ip_addr     <= wr_bus.wdata;
                default:      ;                               // read only or unused
            endcase
        end
    end

    // strobes in the write cycle itself
    assign wdog_kick      = reg_wr && (waddr_u.regs.reg_idx == `REG_STATUS);   // any status write
    assign wdog_period_wr = reg_wr && (waddr_u.regs.reg_idx == `REG_WDOG);
    assign lreq_start     = reg_wr && (waddr_u.regs.reg_idx == `REG_PHYCTRL);
    assign lreq_type      = wr_bus.wdata[12] ? `LREQ_REG_WR : `LREQ_REG_RD;   // bit 12 selects write
    assign lreq_data      = wr_bus.wdata[11:0];                              // addr 11:8, data 7:0

    // ----------------------------------------
    // read decode
    // ----------------------------------------
    always_comb
    begin
        case (raddr_u.regs.reg_idx)
            `REG_STATUS:  regs_rdata = {wdog_timeout, 27'd0, board_id};
            `REG_PHYCTRL: regs_rdata = phy_ctrl;
            `REG_WDOG:    regs_rdata = {16'd0, wdog_period};
            `REG_VERSION: regs_rdata = `FW_VERSION;
            `REG_IPADDR:  regs_rdata = ip_addr;
            default:      regs_rdata = 32'd0;
        endcase
    end

endmodule

//--- hdl/bus_arbiter.sv
// read and write bus arbiters with FireWire priority and routing of the granted host's bus
`timescale 1ns/100ps

module bus_arbiter
(
    input  logic                      sysclk,
    input  logic                      rst,
    input  host_bus_pkg::host_rd_req_t fw_rd,
    input  host_bus_pkg::host_rd_req_t eth_rd,
    input  host_bus_pkg::host_wr_req_t fw_wr,
    input  host_bus_pkg::host_wr_req_t eth_wr,
    output logic                      fw_grant_read,
    output logic                      eth_grant_read,
    output logic                      fw_grant_write,
    output logic                      eth_grant_write,
    output logic [15:0]               reg_raddr,
    output host_bus_pkg::wr_bus_t     wr_bus
);

    // ----------------------------------------
    // grants, one cycle after the requests
    // ----------------------------------------
    // FireWire wins a tie and parks on both buses when nobody asks
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            fw_grant_read   <= 1'b0;
            eth_grant_read  <= 1'b0;
            fw_grant_write  <= 1'b0;
            eth_grant_write <= 1'b0;
        end
        else
        begin
            fw_grant_read   <= fw_rd.req | ~eth_rd.req;      // request or idle
            eth_grant_read  <= ~fw_rd.req & eth_rd.req;      // only when FireWire quiet
            fw_grant_write  <= fw_wr.req | ~eth_wr.req;
            eth_grant_write <= ~fw_wr.req & eth_wr.req;
        end
    end

    // ----------------------------------------
    // routing of the granted host
    // ----------------------------------------
    assign reg_raddr = eth_grant_read ? eth_rd.raddr : fw_rd.raddr;   // FireWire by default
    assign wr_bus    = eth_grant_write ? eth_wr.bus : fw_wr.bus;      // strobes follow grant

endmodule

//--- hdl/host_bus_hub.sv
// register bus hub top with arbiter, read path, board registers, watchdog and link requests
`timescale 1ns/100ps

module host_bus_hub
(
    input  logic                      sysclk,
    input  logic                      rst,
    input  logic [3:0]                board_id,
    input  host_bus_pkg::host_rd_req_t fw_rd,
    input  host_bus_pkg::host_rd_req_t eth_rd,
    input  host_bus_pkg::host_wr_req_t fw_wr,
    input  host_bus_pkg::host_wr_req_t eth_wr,
    input  logic [31:0]               reg_rdata_ext,
    input  logic                      reg_rwait_ext,
    input  logic                      wdog_clear,
    output logic                      fw_grant_read,
    output logic                      eth_grant_read,
    output logic                      fw_grant_write,
    output logic                      eth_grant_write,
    output logic [15:0]               reg_raddr,
    output host_bus_pkg::wr_bus_t     wr_bus,
    output logic [31:0]               reg_rdata,
    output logic                      reg_rwait,
    output logic                      reg_rvalid,
    output logic                      lreq,
    output logic                      wdog_timeout
);

    logic [31:0] regs_rdata;               // board register read data
    logic [15:0] wdog_period;
    logic        wdog_kick;
    logic        wdog_period_wr;
    logic        lreq_start;
    logic [2:0]  lreq_type;
    logic [11:0] lreq_data;

    // ----------------------------------------
    // bus arbitration
    // ----------------------------------------
    bus_arbiter arb (
        .sysclk(sysclk), .rst(rst),
        .fw_rd(fw_rd), .eth_rd(eth_rd),
        .fw_wr(fw_wr), .eth_wr(eth_wr),
        .fw_grant_read(fw_grant_read), .eth_grant_read(eth_grant_read),
        .fw_grant_write(fw_grant_write), .eth_grant_write(eth_grant_write),
        .reg_raddr(reg_raddr),
        .wr_bus(wr_bus)
    );

    read_data_mux rd_mux (
        .sysclk(sysclk), .rst(rst),
        .reg_raddr(reg_raddr),
        .regs_rdata(regs_rdata),
        .reg_rdata_ext(reg_rdata_ext),
        .reg_rwait_ext(reg_rwait_ext),
        .reg_rdata(reg_rdata),
        .reg_rwait(reg_rwait),
        .reg_rvalid(reg_rvalid)
    );

    // ----------------------------------------
    // board registers and their side blocks
    // ----------------------------------------
    board_regs regs (
        .sysclk(sysclk), .rst(rst),
        .reg_raddr(reg_raddr),
        .wr_bus(wr_bus),
        .board_id(board_id),
        .wdog_timeout(wdog_timeout),
        .regs_rdata(regs_rdata),
        .wdog_period(wdog_period),
        .wdog_kick(wdog_kick),
        .wdog_period_wr(wdog_period_wr),
        .lreq_start(lreq_start),
        .lreq_type(lreq_type),
        .lreq_data(lreq_data)
    );

    watchdog_timer wdog (
        .sysclk(sysclk), .rst(rst),
        .wdog_period(wdog_period),
        .wdog_kick(wdog_kick),
        .wdog_period_wr(wdog_period_wr),
        .wdog_clear(wdog_clear),
        .wdog_timeout(wdog_timeout)        // also back to status register
    );

    phy_request phy_req (
        .sysclk(sysclk), .rst(rst),
        .lreq_start(lreq_start),
        .lreq_type(lreq_type),
        .lreq_data(lreq_data),
        .lreq(lreq)
    );

endmodule

//--- hdl/host_bus_pkg.sv
// host read and write request structs, shared write bus struct, register address union
package host_bus_pkg;

    // write bus as seen by the board
    typedef struct packed {
        logic        wen;                   // quadlet write strobe
        logic        blk_wen;               // block write strobe
        logic        blk_wstart;            // block write is starting
        logic [15:0] waddr;
        logic [31:0] wdata;
    } wr_bus_t;

    // read request from one host
    typedef struct packed {
        logic        req;                   // host wants the read bus
        logic [15:0] raddr;
    } host_rd_req_t;

    // write request from one host
    typedef struct packed {
        logic        req;                   // host wants the write bus
        wr_bus_t     bus;
    } host_wr_req_t;

    // ----------------------------------------
    // one address word, two decodes
    // ----------------------------------------
    typedef struct packed {
        logic [3:0]  space;
        logic [3:0]  unused;
        logic [3:0]  chan;                  // 0 for board registers
        logic [3:0]  reg_idx;
    } reg_view_t;

    typedef struct packed {
        logic [3:0]  space;
        logic [11:0] offset;                // word offset in memory space
    } mem_view_t;

    typedef union packed {
        reg_view_t   regs;
        mem_view_t   mem;
    } reg_addr_u;

endpackage

//--- hdl/host_bus_settings.svh
// address space codes, board register indices, link-request codes, firmware version, watchdog tick
`ifndef HOST_BUS_SETTINGS_SVH
`define HOST_BUS_SETTINGS_SVH

// ----------------------------------------
// address spaces in bits 15:12
// ----------------------------------------
`define ADDR_MAIN           4'h0            // board registers, no wait state
`define ADDR_EXT            4'h8            // external memory, one wait state

// ----------------------------------------
// board register indices in bits 3:0
// ----------------------------------------
`define REG_STATUS          4'd0            // board id, timeout flag, write kicks watchdog
`define REG_PHYCTRL         4'd1            // write issues a link request
`define REG_WDOG            4'd3            // watchdog period in tick units
`define REG_VERSION         4'd4            // firmware version, read only
`define REG_IPADDR          4'd11           // ip address of this board

// ----------------------------------------
// link request types sent on lreq
// ----------------------------------------
`define LREQ_REG_RD         3'd1            // phy register read
`define LREQ_REG_WR         3'd5            // phy register write

`define FW_VERSION          32'h0000_0108   // firmware version word

// sysclk cycles in one watchdog period unit
`define WDOG_TICK_CYCLES    16

`endif

//--- hdl/phy_request.sv
// link-request serializer driving lreq from a loaded frame
`timescale 1ns/100ps
`include "host_bus_settings.svh"

module phy_request
(
    input  logic        sysclk,
    input  logic        rst,
    input  logic        lreq_start,        // one cycle pulse
    input  logic [2:0]  lreq_type,
    input  logic [11:0] lreq_data,         // addr 11:8, write data 7:0
    output logic        lreq
);

    localparam int FRAME_W = 17;           // start, type, addr, data, stop
    localparam int RD_LEN  = 9;            // start, type, addr, stop

    logic [FRAME_W-1:0] shift_reg;         // frame, msb goes out first
    logic [4:0]         bit_cnt;           // bits left in the frame
    logic               busy;
    logic               is_write;

    assign busy     = (bit_cnt != 5'd0);
    assign is_write = (lreq_type == `LREQ_REG_WR);

    // ----------------------------------------
    // load and shift
    // ----------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            shift_reg <= '0;
            bit_cnt   <= 5'd0;
        end
        else if (lreq_start && !busy)
        begin
            // trailing zeros after the stop bit keep lreq low once done
            if (is_write)
            begin
                shift_reg <= {1'b1, lreq_type, lreq_data, 1'b0};
                bit_cnt   <= 5'(FRAME_W);
            end
            else
            begin
                shift_reg <= {1'b1, lreq_type, lreq_data[11:8], 1'b0, 8'd0};
                bit_cnt   <= 5'(RD_LEN);
            end
        end
        else if (busy)
        begin
            shift_reg <= {shift_reg[FRAME_W-2:0], 1'b0};
            bit_cnt   <= bit_cnt - 5'd1;
        end
    end

    assign lreq = shift_reg[FRAME_W-1];    // 0 while idle

endmodule

//--- hdl/read_data_mux.sv
// read address decode, read data and wait-state select, read-valid flag
`timescale 1ns/100ps
`include "host_bus_settings.svh"

module read_data_mux
(
    input  logic        sysclk,
    input  logic        rst,
    input  logic [15:0] reg_raddr,
    input  logic [31:0] regs_rdata,        // board register data
    input  logic [31:0] reg_rdata_ext,     // external board data, always ORed
    input  logic        reg_rwait_ext,
    output logic [31:0] reg_rdata,
    output logic        reg_rwait,
    output logic        reg_rvalid
);
    import host_bus_pkg::*;

    reg_addr_u   raddr_u;
    logic        is_main;                  // board register channel
    logic        is_ext;                   // external memory space
    logic [15:0] raddr_prev;               // address at the previous edge

    assign raddr_u = reg_raddr;

    // ----------------------------------------
    // space decode
    // ----------------------------------------
    assign is_main = (raddr_u.regs.space == `ADDR_MAIN) && (raddr_u.regs.chan == 4'd0);
    assign is_ext  = (raddr_u.mem.space == `ADDR_EXT);

    // external space has no internal data, unmapped reads 0
    always_comb
    begin
        reg_rdata = (is_main ? regs_rdata : 32'd0) | reg_rdata_ext;
        reg_rwait = is_ext | reg_rwait_ext;          // main space answers at once
    end

    // ----------------------------------------
    // read valid
    // ----------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            raddr_prev <= 16'd0;
        end
        else
        begin
            raddr_prev <= reg_raddr;
        end
    end

    // with a wait state, data is good one cycle after the address settles
    assign reg_rvalid = ~reg_rwait | (reg_raddr == raddr_prev);

endmodule

//--- hdl/watchdog_timer.sv
// watchdog tick and period counters with sticky timeout flag
`timescale 1ns/100ps
`include "host_bus_settings.svh"

module watchdog_timer
(
    input  logic        sysclk,
    input  logic        rst,
    input  logic [15:0] wdog_period,       // 0 stops the watchdog
    input  logic        wdog_kick,         // restart count
    input  logic        wdog_period_wr,    // restart count, drop timeout
    input  logic        wdog_clear,        // drop timeout
    output logic        wdog_timeout
);

    localparam int TICK   = `WDOG_TICK_CYCLES;
    localparam int TICK_W = $clog2(TICK);

    logic [TICK_W-1:0] tick_cnt;           // cycles within one unit
    logic [15:0]       unit_cnt;           // whole units since restart
    logic              tick_end;

    assign tick_end = (tick_cnt == TICK_W'(TICK - 1));

    always_ff @(posedge sysclk)
    begin
        if (rst || wdog_kick || wdog_period_wr)
        begin
            tick_cnt <= '0;
            unit_cnt <= 16'd0;
        end
        else if ((wdog_period != 16'd0) && !wdog_timeout)
        begin
            tick_cnt <= tick_end ? '0 : tick_cnt + 1'b1;
            if (tick_end)
                unit_cnt <= unit_cnt + 16'd1;
        end
    end

    // ----------------------------------------
    // sticky flag
    // ----------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst || wdog_clear || wdog_period_wr)
            wdog_timeout <= 1'b0;
        else if ((wdog_period != 16'd0) && tick_end && (unit_cnt + 16'd1 == wdog_period))
            wdog_timeout <= 1'b1;          // period times tick cycles since restart
    end

endmodule
